/* flist.f */
+incdir+.
oram_pkg.sv
oram_ifs.sv
positionMap.sv
pathBuffer.sv
pathOramBackend.sv
tinyOramCore.sv
tinyOramCore_chk.sv
tinyOramCore_tb.sv

/* oram_ifs.sv */
//----------------------------------------------------------------------
// Internal links of the ORAM core: front end to back end commands,
// and path buffer to back end read words with credit return
//----------------------------------------------------------------------

interface backendCmdIf;
	import oram_pkg::*;

	// Request, valid/ready handshake
	logic      valid;
	logic      ready;
	oramCmdT   cmd;
	progAddrT  addr;
	leafT      oldLeaf;
	leafT      newLeaf;
	blockDataT storeData;

	// Old block value, one-cycle pulse after the path read
	blockDataT loadData;
	logic      loadValid;

	modport front(output valid, cmd, addr, oldLeaf, newLeaf, storeData,
		input ready, loadData, loadValid);
	modport back(input valid, cmd, addr, oldLeaf, newLeaf, storeData,
		output ready, loadData, loadValid);
endinterface

interface pathReadIf;
	import oram_pkg::*;

	// Head word of the buffer
	dramWordT data;
	logic     valid;
	// Sink takes the head word
	logic     pop;
	// One pulse per popped word, frees one DRAM read credit
	logic     credit;

	modport buffer(output data, valid, credit, input pop);
	modport sink(input data, valid, credit, output pop);
endinterface

/* oram_macros.svh */
//----------------------------------------------------------------------
// Tree geometry, field widths and seeds for the Path ORAM core
// Included by the package and by every module that sizes storage
//----------------------------------------------------------------------
`ifndef ORAM_MACROS_SVH
`define ORAM_MACROS_SVH

// Tree shape, levels below the root
`define ORAML 3
// Block slots per bucket
`define ORAMZ 2
// Heap-ordered buckets in the whole tree
`define NUMBUCKETS 15
// DRAM words on one root-to-leaf path
`define PATHWORDS 8

// Program address and block widths
`define ORAMU 4
`define ORAMB 32
// Stash covers every program block
`define STASHSIZE 16

// DRAM word address and slot word width
`define DDRAWIDTH 5
`define DDRDWIDTH (1 + `ORAMU + `ORAML + `ORAMB)

// Leaf remap generator start value, must be nonzero
`define LFSRSEED 16'hACE1

`endif

/* oram_pkg.sv */
//----------------------------------------------------------------------
// Shared types of the ORAM core: addresses, leaves, data, DRAM slots
// and state encodings; widths come from the macro header
//----------------------------------------------------------------------
`include "oram_macros.svh"

package oram_pkg;

	// Program side
	typedef logic [`ORAMU-1:0] progAddrT;
	typedef logic [`ORAML-1:0] leafT;
	typedef logic [`ORAMB-1:0] blockDataT;

	// DRAM word address, bucket heap index times slots plus slot
	typedef logic [`DDRAWIDTH-1:0] dramAddrT;

	// One tree slot, packed as {valid, progAddr, leaf, data}
	typedef logic [`DDRDWIDTH-1:0] dramWordT;

	// User request kind
	typedef enum logic {
		CmdRead,
		CmdWrite
	} oramCmdT;

	// DRAM command kind
	typedef enum logic {
		DramRead,
		DramWrite
	} dramCmdT;

	// Front end sequencing
	typedef enum logic [2:0] {
		FIdle,
		FWaitData,
		FIssue,
		FWaitLoad,
		FReturn
	} frontStateT;

	// Back end sequencing, one path access at a time
	typedef enum logic [2:0] {
		BIdle,
		BRead,
		BUpdate,
		BSelect,
		BWrite
	} backStateT;

endpackage

/* pathBuffer.sv */
//----------------------------------------------------------------------
// One-path FIFO for DRAM read words; no ready toward DRAM, the back
// end's credits keep it from overflowing
//----------------------------------------------------------------------
`include "oram_macros.svh"

module pathBuffer (
	input  logic               Clock,
	input  logic               rst,
	input  oram_pkg::dramWordT dramReadData,
	input  logic               dramReadDataValid,
	pathReadIf.buffer          pr
);
	import oram_pkg::*;

	localparam int PtrW = $clog2(`PATHWORDS);
	localparam int CntW = $clog2(`PATHWORDS + 1);

	dramWordT        mem [`PATHWORDS];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;
	logic            popFire;

	// Head word straight from storage
	assign pr.valid = (count != '0);
	assign pr.data = mem[rdPtr];
	assign popFire = pr.pop && pr.valid;

	// Storage, written on every DRAM beat
	always_ff @(posedge Clock) begin
		if (dramReadDataValid) mem[wrPtr] <= dramReadData;
	end

	// Pointers wrap at path depth
	always_ff @(posedge Clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			pr.credit <= 1'b0;
		end else begin
			if (dramReadDataValid) wrPtr <= wrPtr + 1'b1;
			if (popFire) rdPtr <= rdPtr + 1'b1;
			count <= count + CntW'(dramReadDataValid) - CntW'(popFire);
			// Hand the slot back a cycle after the pop
			pr.credit <= popFire;
		end
	end

endmodule

/* pathOramBackend.sv */
//----------------------------------------------------------------------
// Back end: reads a whole path into the stash, updates the target
// block, then evicts greedily from leaf to root with DRAM writes
//----------------------------------------------------------------------
`include "oram_macros.svh"

module pathOramBackend (
	input  logic               Clock,
	input  logic               rst,
	backendCmdIf.back          be,
	pathReadIf.sink            pr,
	output oram_pkg::dramAddrT dramAddress,
	output oram_pkg::dramCmdT  dramCommand,
	output logic               dramCommandValid,
	input  logic               dramCommandReady,
	output oram_pkg::dramWordT dramWriteData,
	output logic               dramWriteDataValid,
	input  logic               dramWriteDataReady
);
	import oram_pkg::*;

	localparam int CntW = $clog2(`PATHWORDS + 1);
	localparam int IdxW = $clog2(`PATHWORDS);
	localparam int LvlW = $clog2(`ORAML + 1);
	localparam int SlotW = $clog2(`ORAMZ);
	localparam int BucketW = $clog2(`NUMBUCKETS);

	backStateT       state;
	logic [CntW-1:0] credits;
	logic [CntW-1:0] rdIssued;
	logic [CntW-1:0] popCnt;
	logic [IdxW-1:0] evIdx;
	logic [LvlW-1:0] evLevel;
	logic            cmdDone;
	logic            dataDone;
	logic            readValid;
	logic            rdFire;
	logic            wrCmdFire;
	logic            wrDataFire;
	logic            loadValid;

	// Latched request
	oramCmdT   reqCmd;
	progAddrT  reqAddr;
	leafT      oldLeaf;
	leafT      newLeaf;
	blockDataT storeData;
	blockDataT loadData;

	// Stash, one entry per program address
	logic      stValid [`STASHSIZE];
	leafT      stLeaf [`STASHSIZE];
	blockDataT stData [`STASHSIZE];

	// Popped word fields
	logic      popV;
	progAddrT  popAddr;
	leafT      popLeaf;
	blockDataT popData;

	// Eviction choice for the current slot
	logic      evFound;
	progAddrT  evPick;
	dramWordT  wrWord;

	// Heap bucket on the path to leaf at level lvl, then slot offset
	function automatic dramAddrT slotAddr(input leafT leaf, input logic [LvlW-1:0] lvl,
		input logic [SlotW-1:0] slot);
		logic [BucketW-1:0] bucket;
		bucket = BucketW'((1 << lvl) - 1) + BucketW'(leaf >> (`ORAML - lvl));
		return dramAddrT'(bucket * `ORAMZ + slot);
	endfunction

	//------------------------------------------------------------------
	// DRAM and link outputs
	//------------------------------------------------------------------
	// Credits only drop on acceptance, so valid holds once raised
	assign readValid = (state == BRead) && (rdIssued < CntW'(`PATHWORDS)) && (credits != '0);
	assign rdFire = readValid && dramCommandReady;
	assign wrCmdFire = (state == BWrite) && !cmdDone && dramCommandReady;
	assign wrDataFire = (state == BWrite) && !dataDone && dramWriteDataReady;

	// Leaf bucket first on write-back
	assign evLevel = LvlW'(`ORAML) - evIdx[IdxW-1:SlotW];

	assign dramCommandValid = readValid || ((state == BWrite) && !cmdDone);
	assign dramCommand = (state == BWrite) ? DramWrite : DramRead;
	assign dramAddress = (state == BWrite) ? slotAddr(oldLeaf, evLevel, evIdx[SlotW-1:0]) :
		slotAddr(oldLeaf, rdIssued[IdxW-1:SlotW], rdIssued[SlotW-1:0]);
	assign dramWriteData = wrWord;
	assign dramWriteDataValid = (state == BWrite) && !dataDone;

	assign pr.pop = (state == BRead) && pr.valid;
	assign be.ready = (state == BIdle);
	assign be.loadData = loadData;
	assign be.loadValid = loadValid;

	always_comb begin
		{popV, popAddr, popLeaf, popData} = pr.data;
	end

	// First stash entry whose leaf shares the path down to evLevel
	always_comb begin
		int shamt;
		shamt = `ORAML - int'(evLevel);
		evFound = 1'b0;
		evPick = '0;
		for (int i = 0; i < `STASHSIZE; i++) begin
			if (!evFound && stValid[i] && ((stLeaf[i] >> shamt) == (oldLeaf >> shamt))) begin
				evFound = 1'b1;
				evPick = progAddrT'(i);
			end
		end
	end

	//------------------------------------------------------------------
	// Sequencing, credits and stash occupancy
	//------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= BIdle;
			credits <= CntW'(`PATHWORDS);
			rdIssued <= '0;
			popCnt <= '0;
			evIdx <= '0;
			cmdDone <= 1'b0;
			dataDone <= 1'b0;
			loadValid <= 1'b0;
			for (int i = 0; i < `STASHSIZE; i++) begin
				stValid[i] <= 1'b0;
			end
		end else begin
			loadValid <= 1'b0;
			credits <= credits + CntW'(pr.credit) - CntW'(rdFire);
			case (state)
				BIdle: begin
					rdIssued <= '0;
					popCnt <= '0;
					if (be.valid) state <= BRead;
				end
				BRead: begin
					if (rdFire) rdIssued <= rdIssued + 1'b1;
					if (pr.pop) begin
						popCnt <= popCnt + 1'b1;
						// Dummy slots are dropped
						if (popV) stValid[popAddr] <= 1'b1;
						if (popCnt == CntW'(`PATHWORDS - 1)) state <= BUpdate;
					end
				end
				BUpdate: begin
					loadValid <= 1'b1;
					if (reqCmd == CmdWrite) stValid[reqAddr] <= 1'b1;
					evIdx <= '0;
					state <= BSelect;
				end
				BSelect: begin
					// Chosen block leaves the stash
					if (evFound) stValid[evPick] <= 1'b0;
					cmdDone <= 1'b0;
					dataDone <= 1'b0;
					state <= BWrite;
				end
				BWrite: begin
					if (wrCmdFire) cmdDone <= 1'b1;
					if (wrDataFire) dataDone <= 1'b1;
					// Both channels done, next slot
					if ((cmdDone || wrCmdFire) && (dataDone || wrDataFire)) begin
						evIdx <= evIdx + 1'b1;
						state <= (evIdx == IdxW'(`PATHWORDS - 1)) ? BIdle : BSelect;
					end
				end
				default: state <= BIdle;
			endcase
		end
	end

	// Request capture, stash payload and write word
	always_ff @(posedge Clock) begin
		if (state == BIdle && be.valid) begin
			reqCmd <= be.cmd;
			reqAddr <= be.addr;
			oldLeaf <= be.oldLeaf;
			newLeaf <= be.newLeaf;
			storeData <= be.storeData;
		end
		if (pr.pop && popV) begin
			stLeaf[popAddr] <= popLeaf;
			stData[popAddr] <= popData;
		end
		if (state == BUpdate) begin
			// Absent block reads as zero
			loadData <= stValid[reqAddr] ? stData[reqAddr] : '0;
			stLeaf[reqAddr] <= newLeaf;
			if (reqCmd == CmdWrite) stData[reqAddr] <= storeData;
		end
		if (state == BSelect) begin
			wrWord <= evFound ? {1'b1, evPick, stLeaf[evPick], stData[evPick]} : '0;
		end
	end

endmodule

/* positionMap.sv */
//----------------------------------------------------------------------
// Front end: user handshakes, leaf lookup and remap, load data return
// Issues one back end command per user access
//----------------------------------------------------------------------
`include "oram_macros.svh"

module positionMap (
	input  logic                Clock,
	input  logic                rst,
	input  oram_pkg::oramCmdT   cmd,
	input  oram_pkg::progAddrT  pAddr,
	input  logic                cmdValid,
	output logic                cmdReady,
	input  oram_pkg::blockDataT dataIn,
	input  logic                dataInValid,
	output logic                dataInReady,
	output oram_pkg::blockDataT dataOut,
	output logic                dataOutValid,
	input  logic                dataOutReady,
	backendCmdIf.front          be
);
	import oram_pkg::*;

	localparam int NumBlocks = 1 << `ORAMU;

	frontStateT  state;
	leafT        leafTable [NumBlocks];
	logic [15:0] lfsr;
	logic        lfsrFb;
	logic        cmdFire;

	// Captured request
	oramCmdT     cmdReg;
	progAddrT    addrReg;
	leafT        oldLeafReg;
	leafT        newLeafReg;
	blockDataT   storeReg;
	blockDataT   loadReg;

	// Taps 16,14,13,11 for a maximal sequence
	assign lfsrFb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
	assign cmdFire = cmdValid && cmdReady;

	// User side handshakes
	assign cmdReady = (state == FIdle);
	assign dataInReady = (state == FWaitData);
	assign dataOutValid = (state == FReturn);
	assign dataOut = loadReg;

	// Back end request
	assign be.valid = (state == FIssue);
	assign be.cmd = cmdReg;
	assign be.addr = addrReg;
	assign be.oldLeaf = oldLeafReg;
	assign be.newLeaf = newLeafReg;
	assign be.storeData = storeReg;

	//------------------------------------------------------------------
	// Control and position map
	//------------------------------------------------------------------
	always_ff @(posedge Clock) begin
		if (rst) begin
			state <= FIdle;
			lfsr <= `LFSRSEED;
			for (int i = 0; i < NumBlocks; i++) begin
				leafTable[i] <= '0;
			end
		end else begin
			// Free running, sampled on acceptance
			lfsr <= {lfsr[14:0], lfsrFb};
			case (state)
				FIdle: begin
					if (cmdFire) begin
						// Remap now, old leaf goes with the command
						leafTable[pAddr] <= lfsr[`ORAML-1:0];
						state <= (cmd == CmdWrite) ? FWaitData : FIssue;
					end
				end
				FWaitData: begin
					if (dataInValid) state <= FIssue;
				end
				FIssue: begin
					if (be.ready) state <= FWaitLoad;
				end
				FWaitLoad: begin
					// Writes finish here, reads return data
					if (be.loadValid) state <= (cmdReg == CmdRead) ? FReturn : FIdle;
				end
				FReturn: begin
					if (dataOutReady) state <= FIdle;
				end
				default: state <= FIdle;
			endcase
		end
	end

	// Request payload
	always_ff @(posedge Clock) begin
		if (state == FIdle && cmdFire) begin
			cmdReg <= cmd;
			addrReg <= pAddr;
			oldLeafReg <= leafTable[pAddr];
			newLeafReg <= lfsr[`ORAML-1:0];
		end
		if (state == FWaitData && dataInValid) storeReg <= dataIn;
		// Held through dataOut back-pressure
		if (state == FWaitLoad && be.loadValid) loadReg <= be.loadData;
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile and run the ORAM core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir run.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps -f flist.f \
	--top-module tinyOramCore_tb -o tbSim > run.log 2>&1 &&
	./obj_dir/tbSim >> run.log 2>&1
cat run.log
grep -q "Testbench passed" run.log && ! grep -q "Testbench failed" run.log &&
	echo "PASS" || { echo "FAIL, see run.log"; exit 1; }

/* tinyOramCore.sv */
//----------------------------------------------------------------------
// Path ORAM core top: front end, back end and path buffer joined by
// the internal links; user and DRAM sides are plain valid/ready
//----------------------------------------------------------------------

module tinyOramCore (
	input  logic                Clock,
	input  logic                rst,

	// User side
	input  oram_pkg::oramCmdT   cmd,
	input  oram_pkg::progAddrT  pAddr,
	input  logic                cmdValid,
	output logic                cmdReady,
	input  oram_pkg::blockDataT dataIn,
	input  logic                dataInValid,
	output logic                dataInReady,
	output oram_pkg::blockDataT dataOut,
	output logic                dataOutValid,
	input  logic                dataOutReady,

	// DRAM side
	output oram_pkg::dramAddrT  dramAddress,
	output oram_pkg::dramCmdT   dramCommand,
	output logic                dramCommandValid,
	input  logic                dramCommandReady,
	input  oram_pkg::dramWordT  dramReadData,
	input  logic                dramReadDataValid,
	output oram_pkg::dramWordT  dramWriteData,
	output logic                dramWriteDataValid,
	input  logic                dramWriteDataReady
);

	backendCmdIf beIf ();
	pathReadIf   prIf ();

	// Leaf lookup and user data
	positionMap frontEnd (
		.Clock,
		.rst,
		.cmd,
		.pAddr,
		.cmdValid,
		.cmdReady,
		.dataIn,
		.dataInValid,
		.dataInReady,
		.dataOut,
		.dataOutValid,
		.dataOutReady,
		.be(beIf.front)
	);

	// DRAM read landing
	pathBuffer readBuf (
		.Clock,
		.rst,
		.dramReadData,
		.dramReadDataValid,
		.pr(prIf.buffer)
	);

	// Stash and path sequencing
	pathOramBackend backEnd (
		.Clock,
		.rst,
		.be(beIf.back),
		.pr(prIf.sink),
		.dramAddress,
		.dramCommand,
		.dramCommandValid,
		.dramCommandReady,
		.dramWriteData,
		.dramWriteDataValid,
		.dramWriteDataReady
	);

endmodule

/* tinyOramCore_chk.sv */
//----------------------------------------------------------------------
// Concurrent checks on the back end: credit bound, stalled DRAM
// command stability and pops only from a non-empty path buffer
//----------------------------------------------------------------------
`include "oram_macros.svh"

module tinyOramCore_chk (
	input logic                                 Clock,
	input logic                                 rst,
	input logic [$clog2(`PATHWORDS + 1)-1:0]    credits,
	input logic                                 dramCommandValid,
	input logic                                 dramCommandReady,
	input oram_pkg::dramAddrT                   dramAddress,
	input oram_pkg::dramCmdT                    dramCommand,
	input logic                                 pop
);
	timeunit 1ns;
	timeprecision 1ps;

	// Never more credits than buffer words
	creditBound: assert property (@(posedge Clock) disable iff (rst)
		credits <= `PATHWORDS)
		else $error("DRAM read credits above the path buffer depth");

	// Stalled command holds valid, kind and address
	cmdHeld: assert property (@(posedge Clock) disable iff (rst)
		dramCommandValid && !dramCommandReady |=>
		dramCommandValid && $stable(dramAddress) && $stable(dramCommand))
		else $error("DRAM command changed while stalled");

	// A popped word still holds the credit of its read command
	popGuard: assert property (@(posedge Clock) disable iff (rst)
		pop |-> credits < `PATHWORDS)
		else $error("pop from an empty path buffer");

endmodule

bind pathOramBackend tinyOramCore_chk chk (
	.Clock,
	.rst,
	.credits,
	.dramCommandValid,
	.dramCommandReady,
	.dramAddress,
	.dramCommand,
	.pop(pr.pop)
);

/* tinyOramCore_tb.sv */
//----------------------------------------------------------------------
// Testbench for the Path ORAM core: DRAM model, random user traffic,
// shadow memory reference, path order checks and a cycle limit
//----------------------------------------------------------------------
`include "oram_macros.svh"

module tinyOramCore_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import oram_pkg::*;

	localparam int NumOps = 64;
	localparam int OpCycles = 150;
	localparam int CycleLimit = NumOps * OpCycles;
	localparam int DramWords = 30;

	logic Clock;
	logic rst;
	oramCmdT cmd;
	progAddrT pAddr;
	logic cmdValid;
	logic cmdReady;
	blockDataT dataIn;
	logic dataInValid;
	logic dataInReady;
	blockDataT dataOut;
	logic dataOutValid;
	logic dataOutReady;
	dramAddrT dramAddress;
	dramCmdT dramCommand;
	logic dramCommandValid;
	logic dramCommandReady;
	dramWordT dramReadData;
	logic dramReadDataValid;
	dramWordT dramWriteData;
	logic dramWriteDataValid;
	logic dramWriteDataReady;

	// Reference state and DRAM model storage
	blockDataT shadow [16];
	blockDataT expQ [$];
	dramWordT dramMem [DramWords];
	dramWordT retQ [$];
	int retDue [$];
	dramAddrT wrAddrQ [$];
	dramWordT wrDataQ [$];
	int pathBucket [`ORAML + 1];
	int cycles = 0;
	int accesses = 0;
	int cmdIdx = 0;
	int cmdTotal = 0;
	logic [31:0] opRng = 32'h3af6;
	logic [31:0] stallRng = ~32'h3af6;

	tinyOramCore dut (.*);

	initial Clock = 1'b0;
	always #50 Clock = ~Clock;

	//------------------------------------------------------------------
	// Helpers
	//------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		return s;
	endfunction

	// Expected load value, zero until first written
	function automatic blockDataT refLoad(input progAddrT a);
		return shadow[a];
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic checkData(input blockDataT got, input blockDataT exp);
		if (got !== exp)
			abortRun($sformatf("Fail at %0t ns: dataOut %h, expected %h", $time, got, exp));
	endtask

	task automatic checkAddr(input dramAddrT got, input dramAddrT exp);
		if (got !== exp)
			abortRun($sformatf("Fail at %0t ns: DRAM address %0d, expected %0d", $time, got, exp));
	endtask

	task automatic checkCmd(input dramCmdT got, input dramCmdT exp);
		if (got !== exp)
			abortRun($sformatf("Fail at %0t ns: DRAM command %s, expected %s", $time,
				got.name(), exp.name()));
	endtask

	// Reads walk root to leaf, writes revisit the same buckets leaf to root
	task automatic trackPathCommand();
		int lvl;
		int slot;
		int bucket;
		int cand;
		if (cmdIdx < `PATHWORDS) begin
			lvl = cmdIdx / `ORAMZ;
			slot = cmdIdx % `ORAMZ;
			checkCmd(dramCommand, DramRead);
			if (lvl == 0) begin
				bucket = 0;
			end else if (slot == 0) begin
				// Either child of the bucket above
				cand = int'(dramAddress) / `ORAMZ;
				bucket = (cand == 2 * pathBucket[lvl - 1] + 2) ? cand : 2 * pathBucket[lvl - 1] + 1;
			end else begin
				bucket = pathBucket[lvl];
			end
			pathBucket[lvl] = bucket;
		end else begin
			lvl = `ORAML - (cmdIdx - `PATHWORDS) / `ORAMZ;
			slot = (cmdIdx - `PATHWORDS) % `ORAMZ;
			checkCmd(dramCommand, DramWrite);
			bucket = pathBucket[lvl];
		end
		checkAddr(dramAddress, dramAddrT'(bucket * `ORAMZ + slot));
		cmdIdx = (cmdIdx + 1) % (2 * `PATHWORDS);
		cmdTotal++;
	endtask

	// Handshakes are observed at the falling edge, released after the rising one
	task automatic acceptCommand(input oramCmdT c, input progAddrT a);
		cmd = c;
		pAddr = a;
		cmdValid = 1'b1;
		do @(negedge Clock); while (!cmdReady);
		@(posedge Clock);
		#5;
		cmdValid = 1'b0;
		accesses++;
	endtask

	task automatic issueWrite(input progAddrT a, input blockDataT d);
		acceptCommand(CmdWrite, a);
		dataIn = d;
		dataInValid = 1'b1;
		do @(negedge Clock); while (!dataInReady);
		@(posedge Clock);
		#5;
		dataInValid = 1'b0;
		shadow[a] = d;
	endtask

	task automatic issueRead(input progAddrT a);
		acceptCommand(CmdRead, a);
		expQ.push_back(refLoad(a));
		do @(negedge Clock); while (!(dataOutValid && dataOutReady));
		@(posedge Clock);
		#5;
	endtask

	//------------------------------------------------------------------
	// DRAM model, stalls, comparison and cycle limit
	//------------------------------------------------------------------
	always @(posedge Clock) begin
		cycles++;
		if (cycles >= CycleLimit)
			abortRun("Timeout: the accesses did not finish within the cycle limit");
	end

	// Read words come back two cycles after the command
	always @(posedge Clock) begin
		#5;
		if (retQ.size() != 0 && retDue[0] <= cycles) begin
			dramReadData = retQ.pop_front();
			void'(retDue.pop_front());
			dramReadDataValid = 1'b1;
		end else begin
			dramReadDataValid = 1'b0;
		end
	end

	always @(negedge Clock) begin
		if (!rst && dramCommandValid && dramCommandReady) begin
			trackPathCommand();
			if (dramCommand == DramRead) begin
				retQ.push_back(dramMem[dramAddress]);
				retDue.push_back(cycles + 2);
			end else begin
				wrAddrQ.push_back(dramAddress);
			end
		end
		if (!rst && dramWriteDataValid && dramWriteDataReady)
			wrDataQ.push_back(dramWriteData);
		// Pair write commands with write words in order
		while (wrAddrQ.size() != 0 && wrDataQ.size() != 0)
			dramMem[wrAddrQ.pop_front()] = wrDataQ.pop_front();
	end

	// About one stall cycle in four per channel
	always @(posedge Clock) begin
		#5;
		stallRng = xorshift32(stallRng);
		dramCommandReady = (stallRng[1:0] != 2'b00);
		dramWriteDataReady = (stallRng[3:2] != 2'b00);
		dataOutReady = (stallRng[5:4] != 2'b00);
	end

	always @(negedge Clock) begin
		if (!rst && dataOutValid && dataOutReady) begin
			if (expQ.size() == 0)
				abortRun("dataOut delivered a word with no read pending");
			else
				checkData(dataOut, expQ.pop_front());
		end
	end

	//------------------------------------------------------------------
	// Stimulus
	//------------------------------------------------------------------
	initial begin
		progAddrT a;
		rst = 1'b1;
		cmd = CmdRead;
		pAddr = '0;
		cmdValid = 1'b0;
		dataIn = '0;
		dataInValid = 1'b0;
		dataOutReady = 1'b1;
		dramCommandReady = 1'b1;
		dramWriteDataReady = 1'b1;
		dramReadData = '0;
		dramReadDataValid = 1'b0;
		for (int i = 0; i < DramWords; i++) dramMem[i] = '0;
		for (int i = 0; i < 16; i++) shadow[i] = '0;
		repeat (3) @(posedge Clock);
		#5;
		rst = 1'b0;

		// Never written, then write and read back
		issueRead(4'h9);
		issueWrite(4'h3, 32'h5a5a_0f0f);
		issueRead(4'h3);

		for (int n = 0; n < NumOps; n++) begin
			opRng = xorshift32(opRng);
			a = opRng[4:1];
			if (opRng[8]) begin
				opRng = xorshift32(opRng);
				issueWrite(a, opRng);
			end else begin
				issueRead(a);
			end
		end

		// Last write-back must reach DRAM
		do @(negedge Clock); while (cmdTotal != accesses * 2 * `PATHWORDS);
		if (expQ.size() == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			abortRun("some read data never came back on dataOut");
		end
	end

endmodule
